// ==== hw/ntps_pkg.sv ====
// NTP server control package
// Register bus types, slave address map and register offsets

package ntps_pkg;

  // ------------------------------
  // Basic types
  // ------------------------------
  typedef logic [31:0] reg_word_t;

  // Upper nibble picks the slave, lower nibble the register
  typedef logic [7:0]  host_addr_t;
  typedef logic [3:0]  reg_ofs_t;

  // Seconds in the upper word, fraction in the lower word
  typedef logic [63:0] ntp_time_t;

  typedef logic [4:0]  xphy_status_t;

  // ------------------------------
  // Slave indices
  // ------------------------------
  localparam logic [3:0] SLAVE_NTP   = 4'd0;
  localparam logic [3:0] SLAVE_PORTS = 4'd1;
  localparam logic [3:0] SLAVE_INFO  = 4'd2;

  // NTP clock select registers
  localparam reg_ofs_t NTP_OFS_TIME_HI = 4'd0;
  localparam reg_ofs_t NTP_OFS_TIME_LO = 4'd1;
  localparam reg_ofs_t NTP_OFS_STATUS  = 4'd2;

  // Port config at offset p, port status from here on
  localparam reg_ofs_t PORT_OFS_STATUS_BASE = 4'd4;

  // Board info registers
  localparam reg_ofs_t INFO_OFS_BUILD = 4'd0;
  localparam reg_ofs_t INFO_OFS_GIT   = 4'd1;
  localparam reg_ofs_t INFO_OFS_LINK  = 4'd2;

  // Port 0 config bit that switches the common time to source B
  localparam int CLK_SEL_BIT = 24;

  localparam reg_word_t BUS_ERR_DATA = 32'hDEAD_BEEF;

endpackage

// ==== hw/reg_bus_if.sv ====
// Internal register bus between the host decoder and one slave
// Single-cycle select strobe, registered read data one cycle later

`timescale 1ns/10ps

interface reg_bus_if;

  logic                sel;
  logic                we;
  ntps_pkg::reg_ofs_t  offset;
  ntps_pkg::reg_word_t wdata;

  // Read response
  ntps_pkg::reg_word_t rdata;
  logic                rvalid;

  modport master (
    output sel, we, offset, wdata,
    input  rdata, rvalid
  );

  modport slave (
    input  sel, we, offset, wdata,
    output rdata, rvalid
  );

endinterface

// ==== hw/host_bus_decoder.sv ====
// Host register bus decoder
// Routes host requests to the slave buses and returns read data

`timescale 1ns/10ps

module host_bus_decoder (
  input  logic                 clk156,
  input  logic                 rst_n,
  input  logic                 req,
  input  logic                 we,
  input  ntps_pkg::host_addr_t addr,
  input  ntps_pkg::reg_word_t  wdata,
  output ntps_pkg::reg_word_t  rd_data,
  output logic                 rd_valid,
  reg_bus_if.master            ntp_bus,
  reg_bus_if.master            port_bus,
  reg_bus_if.master            info_bus
);

  logic                req_q;
  logic                we_q;
  logic [3:0]          idx_q;
  ntps_pkg::reg_ofs_t  ofs_q;
  ntps_pkg::reg_word_t wdata_q;

  // Read tracking, one stage behind the bus strobe
  logic                rd_pend_q;
  logic [3:0]          rd_idx_q;

  // ------------------------------
  // Request register
  // ------------------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      req_q     <= 1'b0;
      we_q      <= 1'b0;
      idx_q     <= '0;
      rd_pend_q <= 1'b0;
      rd_idx_q  <= '0;
    end else begin
      req_q     <= req;
      we_q      <= we;
      idx_q     <= addr[7:4];
      rd_pend_q <= req_q && !we_q;
      rd_idx_q  <= idx_q;
    end
  end

  always_ff @(posedge clk156) begin
    ofs_q   <= addr[3:0];
    wdata_q <= wdata;
  end

  // Strobe only the addressed slave
  assign ntp_bus.sel     = req_q && (idx_q == ntps_pkg::SLAVE_NTP);
  assign ntp_bus.we      = we_q;
  assign ntp_bus.offset  = ofs_q;
  assign ntp_bus.wdata   = wdata_q;

  assign port_bus.sel    = req_q && (idx_q == ntps_pkg::SLAVE_PORTS);
  assign port_bus.we     = we_q;
  assign port_bus.offset = ofs_q;
  assign port_bus.wdata  = wdata_q;

  assign info_bus.sel    = req_q && (idx_q == ntps_pkg::SLAVE_INFO);
  assign info_bus.we     = we_q;
  assign info_bus.offset = ofs_q;
  assign info_bus.wdata  = wdata_q;

  // ------------------------------
  // Read data return
  // ------------------------------
  // Unmapped index answers by itself with the error word
  always_comb begin
    rd_data  = ntps_pkg::BUS_ERR_DATA;
    rd_valid = rd_pend_q;
    case (rd_idx_q)
      ntps_pkg::SLAVE_NTP: begin
        rd_data  = ntp_bus.rdata;
        rd_valid = rd_pend_q && ntp_bus.rvalid;
      end
      ntps_pkg::SLAVE_PORTS: begin
        rd_data  = port_bus.rdata;
        rd_valid = rd_pend_q && port_bus.rvalid;
      end
      ntps_pkg::SLAVE_INFO: begin
        rd_data  = info_bus.rdata;
        rd_valid = rd_pend_q && info_bus.rvalid;
      end
      default: ;
    endcase
  end

endmodule

// ==== hw/ntp_clock_select.sv ====
// Common NTP clock select
// Picks source A or B and holds the common time and sync flag

`timescale 1ns/10ps

module ntp_clock_select (
  input  logic                clk156,
  input  logic                rst_n,
  input  logic                select,
  input  ntps_pkg::ntp_time_t ntp_time_a,
  input  logic                ntp_time_upd_a,
  input  logic                ntp_sync_ok_a,
  input  ntps_pkg::ntp_time_t ntp_time_b,
  input  logic                ntp_time_upd_b,
  input  logic                ntp_sync_ok_b,
  output ntps_pkg::ntp_time_t ntp_time,
  output logic                ntp_sync_ok,
  reg_bus_if.slave            bus
);

  ntps_pkg::ntp_time_t src_time;
  logic                src_upd;
  ntps_pkg::reg_word_t rd_word;

  // Source B when select is set
  assign src_time = select ? ntp_time_b : ntp_time_a;
  assign src_upd  = select ? ntp_time_upd_b : ntp_time_upd_a;

  // ------------------------------
  // Common time register
  // ------------------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      ntp_time    <= '0;
      ntp_sync_ok <= 1'b0;
    end else begin
      if (src_upd) begin
        ntp_time <= src_time;
      end
      ntp_sync_ok <= select ? ntp_sync_ok_b : ntp_sync_ok_a;
    end
  end

  // ------------------------------
  // Register reads
  // ------------------------------
  always_comb begin
    case (bus.offset)
      ntps_pkg::NTP_OFS_TIME_HI: rd_word = ntp_time[63:32];
      ntps_pkg::NTP_OFS_TIME_LO: rd_word = ntp_time[31:0];
      ntps_pkg::NTP_OFS_STATUS:  rd_word = {29'h0, ntp_sync_ok_b, ntp_sync_ok_a, select};
      default:                   rd_word = ntps_pkg::BUS_ERR_DATA;
    endcase
  end

  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.sel && !bus.we;
    end
  end

  // Nothing here is writable, writes are dropped
  always_ff @(posedge clk156) begin
    if (bus.sel && !bus.we) begin
      bus.rdata <= rd_word;
    end
  end

endmodule

// ==== hw/port_config_regs.sv ====
// Network port configuration registers
// One config word per port plus PHY status readback

`timescale 1ns/10ps

module port_config_regs #(
  parameter int NUM_PORTS = 4
) (
  input  logic                   clk156,
  input  logic                   rst_n,
  input  ntps_pkg::xphy_status_t xphy_status [NUM_PORTS],
  input  logic                   ntp_sync_ok,
  output ntps_pkg::reg_word_t    gen_config  [NUM_PORTS],
  reg_bus_if.slave               bus
);

  ntps_pkg::reg_word_t rd_word;

  // ------------------------------
  // Config registers
  // ------------------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        gen_config[p] <= '0;
      end
    end else if (bus.sel && bus.we) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (bus.offset == p) begin
          gen_config[p] <= bus.wdata;
        end
      end
    end
  end

  // Config at offset p, status at status base plus p
  always_comb begin
    rd_word = ntps_pkg::BUS_ERR_DATA;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (bus.offset == p) begin
        rd_word = gen_config[p];
      end
      if (bus.offset == ntps_pkg::PORT_OFS_STATUS_BASE + p) begin
        rd_word = {23'h0, ntp_sync_ok, 3'h0, xphy_status[p]};
      end
    end
  end

  // ------------------------------
  // Read response
  // ------------------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.sel && !bus.we;
    end
  end

  always_ff @(posedge clk156) begin
    if (bus.sel && !bus.we) begin
      bus.rdata <= rd_word;
    end
  end

endmodule

// ==== hw/board_info_regs.sv ====
// Board identification registers
// Build info, git hash and sticky PCIe link loss tracking

`timescale 1ns/10ps

module board_info_regs #(
  parameter ntps_pkg::reg_word_t BUILD_INFO = 32'h0,
  parameter ntps_pkg::reg_word_t GIT_HASH   = 32'h0
) (
  input  logic     clk156,
  input  logic     rst_n,
  input  logic     user_link_up,
  reg_bus_if.slave bus
);

  logic                link_up_q;
  logic                link_lost;
  logic                lost_clr;
  ntps_pkg::reg_word_t rd_word;

  // Write 1 to bit 1 of the link word
  assign lost_clr = bus.sel && bus.we && (bus.offset == ntps_pkg::INFO_OFS_LINK)
                    && bus.wdata[1];

  // ------------------------------
  // Link state
  // ------------------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      link_up_q <= 1'b0;
      link_lost <= 1'b0;
    end else begin
      link_up_q <= user_link_up;
      // a fresh drop wins over a clear in the same cycle
      if (link_up_q && !user_link_up) begin
        link_lost <= 1'b1;
      end else if (lost_clr) begin
        link_lost <= 1'b0;
      end
    end
  end

  always_comb begin
    case (bus.offset)
      ntps_pkg::INFO_OFS_BUILD: rd_word = BUILD_INFO;
      ntps_pkg::INFO_OFS_GIT:   rd_word = GIT_HASH;
      ntps_pkg::INFO_OFS_LINK:  rd_word = {30'h0, link_lost, link_up_q};
      default:                  rd_word = ntps_pkg::BUS_ERR_DATA;
    endcase
  end

  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.sel && !bus.we;
    end
  end

  always_ff @(posedge clk156) begin
    if (bus.sel && !bus.we) begin
      bus.rdata <= rd_word;
    end
  end

endmodule

// ==== hw/ntps_ctrl_top.sv ====
// NTP server control top level
// Host register decoder with NTP select, port config and board info slaves

`timescale 1ns/10ps

module ntps_ctrl_top #(
  parameter int                  NUM_PORTS  = 4,
  parameter ntps_pkg::reg_word_t BUILD_INFO = 32'h0,
  parameter ntps_pkg::reg_word_t GIT_HASH   = 32'h0
) (
  input  logic                   clk156,
  input  logic                   rst_n,

  // Host register bus
  input  logic                   req,
  input  logic                   we,
  input  ntps_pkg::host_addr_t   addr,
  input  ntps_pkg::reg_word_t    wdata,
  output ntps_pkg::reg_word_t    rd_data,
  output logic                   rd_valid,

  // NTP time sources
  input  ntps_pkg::ntp_time_t    ntp_time_a,
  input  logic                   ntp_time_upd_a,
  input  logic                   ntp_sync_ok_a,
  input  ntps_pkg::ntp_time_t    ntp_time_b,
  input  logic                   ntp_time_upd_b,
  input  logic                   ntp_sync_ok_b,

  input  ntps_pkg::xphy_status_t xphy_status [NUM_PORTS],
  input  logic                   user_link_up,

  output ntps_pkg::ntp_time_t    ntp_time,
  output logic                   ntp_sync_ok,
  output ntps_pkg::reg_word_t    gen_config  [NUM_PORTS]
);

  reg_bus_if ntp_bus ();
  reg_bus_if port_bus ();
  reg_bus_if info_bus ();

  // ------------------------------
  // Host decoder
  // ------------------------------
  host_bus_decoder u_decoder (
    .clk156   (clk156),
    .rst_n    (rst_n),
    .req      (req),
    .we       (we),
    .addr     (addr),
    .wdata    (wdata),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .ntp_bus  (ntp_bus.master),
    .port_bus (port_bus.master),
    .info_bus (info_bus.master)
  );

  // Common clock select, controlled by port 0 config
  ntp_clock_select u_clock_select (
    .clk156         (clk156),
    .rst_n          (rst_n),
    .select         (gen_config[0][ntps_pkg::CLK_SEL_BIT]),
    .ntp_time_a     (ntp_time_a),
    .ntp_time_upd_a (ntp_time_upd_a),
    .ntp_sync_ok_a  (ntp_sync_ok_a),
    .ntp_time_b     (ntp_time_b),
    .ntp_time_upd_b (ntp_time_upd_b),
    .ntp_sync_ok_b  (ntp_sync_ok_b),
    .ntp_time       (ntp_time),
    .ntp_sync_ok    (ntp_sync_ok),
    .bus            (ntp_bus.slave)
  );

  port_config_regs #(
    .NUM_PORTS (NUM_PORTS)
  ) u_port_regs (
    .clk156      (clk156),
    .rst_n       (rst_n),
    .xphy_status (xphy_status),
    .ntp_sync_ok (ntp_sync_ok),
    .gen_config  (gen_config),
    .bus         (port_bus.slave)
  );

  board_info_regs #(
    .BUILD_INFO (BUILD_INFO),
    .GIT_HASH   (GIT_HASH)
  ) u_board_info (
    .clk156       (clk156),
    .rst_n        (rst_n),
    .user_link_up (user_link_up),
    .bus          (info_bus.slave)
  );

endmodule

// ==== bench/tb_ntps_ctrl_top.sv ====
// Testbench for the NTP server control top level
// Drives host register traffic and NTP sources, checks with assertions

`timescale 1ns/10ps

module tb_ntps_ctrl_top;

  localparam int                  NUM_PORTS_C  = 4;
  localparam ntps_pkg::reg_word_t BUILD_INFO_C = 32'h0103_0042;
  localparam ntps_pkg::reg_word_t GIT_HASH_C   = 32'h9f3c_a1d7;

  logic                   clk156 = 1'b0;
  logic                   rst_n;
  logic                   req;
  logic                   we;
  ntps_pkg::host_addr_t   addr;
  ntps_pkg::reg_word_t    wdata;
  ntps_pkg::reg_word_t    rd_data;
  logic                   rd_valid;
  ntps_pkg::ntp_time_t    ntp_time_a;
  logic                   ntp_time_upd_a;
  logic                   ntp_sync_ok_a;
  ntps_pkg::ntp_time_t    ntp_time_b;
  logic                   ntp_time_upd_b;
  logic                   ntp_sync_ok_b;
  ntps_pkg::xphy_status_t xphy_status [NUM_PORTS_C];
  logic                   user_link_up;
  ntps_pkg::ntp_time_t    ntp_time;
  logic                   ntp_sync_ok;
  ntps_pkg::reg_word_t    gen_config  [NUM_PORTS_C];

  // Expected read data, oldest first
  ntps_pkg::reg_word_t    exp_q [$];
  string                  name_q [$];
  ntps_pkg::reg_word_t    rd_exp;
  string                  rd_name;
  ntps_pkg::reg_word_t    cfg_model [NUM_PORTS_C];
  ntps_pkg::ntp_time_t    exp_time;
  logic                   exp_sync;
  logic                   exp_sel;
  logic                   sel_wr_q;
  logic                   sel_val_q;
  ntps_pkg::ntp_time_t    tval;
  int                     req_count = 0;
  int                     cycle_count = 0;

  always #2 clk156 = ~clk156;

  ntps_ctrl_top #(
    .NUM_PORTS  (NUM_PORTS_C),
    .BUILD_INFO (BUILD_INFO_C),
    .GIT_HASH   (GIT_HASH_C)
  ) DUT (
    .clk156 (clk156), .rst_n (rst_n), .req (req), .we (we), .addr (addr),
    .wdata (wdata), .rd_data (rd_data), .rd_valid (rd_valid),
    .ntp_time_a (ntp_time_a), .ntp_time_upd_a (ntp_time_upd_a),
    .ntp_sync_ok_a (ntp_sync_ok_a), .ntp_time_b (ntp_time_b),
    .ntp_time_upd_b (ntp_time_upd_b), .ntp_sync_ok_b (ntp_sync_ok_b),
    .xphy_status (xphy_status), .user_link_up (user_link_up),
    .ntp_time (ntp_time), .ntp_sync_ok (ntp_sync_ok), .gen_config (gen_config)
  );

  // ------------------------------
  // Failure reporting
  // ------------------------------
  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("ERR %s: expected %h, got %h", name, exp, act);
    abort_run();
  endtask

  task automatic check_failed(input string what);
    $display("%s", what);
    abort_run();
  endtask

  // ------------------------------
  // Host bus stimulus
  // ------------------------------
  function automatic ntps_pkg::host_addr_t reg_addr(input logic [3:0] idx,
                                                     input ntps_pkg::reg_ofs_t ofs);
    return {idx, ofs};
  endfunction

  // One request per call, a read queues its expected data
  task automatic issue(input bit is_wr, input ntps_pkg::host_addr_t a,
                       input ntps_pkg::reg_word_t d, input string name);
    @(posedge clk156);
    req   <= 1'b1;
    we    <= is_wr;
    addr  <= a;
    wdata <= is_wr ? d : ntps_pkg::reg_word_t'($urandom);
    if (!is_wr) begin
      exp_q.push_back(d);
      name_q.push_back(name);
    end
    req_count++;
  endtask

  task automatic bus_idle();
    @(posedge clk156);
    req <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic write_reg(input ntps_pkg::host_addr_t a, input ntps_pkg::reg_word_t d);
    issue(1'b1, a, d, "");
    bus_idle();
  endtask

  task automatic read_check(input ntps_pkg::host_addr_t a, input ntps_pkg::reg_word_t exp,
                            input string name);
    issue(1'b0, a, exp, name);
    bus_idle();
  endtask

  task automatic drain_reads();
    while (exp_q.size() != 0) begin
      @(posedge clk156);
    end
  endtask

  task automatic pulse_time(input bit use_b, input ntps_pkg::ntp_time_t t);
    @(posedge clk156);
    if (use_b) begin
      ntp_time_b     <= t;
      ntp_time_upd_b <= 1'b1;
    end else begin
      ntp_time_a     <= t;
      ntp_time_upd_a <= 1'b1;
    end
    @(posedge clk156);
    ntp_time_upd_a <= 1'b0;
    ntp_time_upd_b <= 1'b0;
  endtask

  // ------------------------------
  // Checkers
  // ------------------------------
  // Expected common time, loaded from the selected source on its update pulse
  always @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      exp_time  <= '0;
      exp_sync  <= 1'b0;
      exp_sel   <= 1'b0;
      sel_wr_q  <= 1'b0;
      sel_val_q <= 1'b0;
    end else begin
      // Select follows a port 0 config write one cycle after the request
      sel_wr_q  <= req && we && addr == {ntps_pkg::SLAVE_PORTS, 4'd0};
      sel_val_q <= wdata[ntps_pkg::CLK_SEL_BIT];
      if (sel_wr_q) begin
        exp_sel <= sel_val_q;
      end
      if (exp_sel ? ntp_time_upd_b : ntp_time_upd_a) begin
        exp_time <= exp_sel ? ntp_time_b : ntp_time_a;
      end
      exp_sync <= exp_sel ? ntp_sync_ok_b : ntp_sync_ok_a;
    end
  end

  assert property (@(posedge clk156) disable iff (!rst_n) req && !we |-> ##2 rd_valid)
    else check_failed("Read response did not arrive 2 cycles after the request");
  assert property (@(posedge clk156) disable iff (!rst_n) rd_valid |-> $past(req && !we, 2))
    else check_failed("Read response came without a read request 2 cycles earlier");
  assert property (@(posedge clk156) disable iff (!rst_n) ntp_time == exp_time)
    else value_error("ntp time", $sampled(exp_time), $sampled(ntp_time));
  assert property (@(posedge clk156) disable iff (!rst_n) ntp_sync_ok == exp_sync)
    else value_error("ntp sync flag", $sampled(exp_sync), $sampled(ntp_sync_ok));

  // Config write reaches gen_config at the edge after the registered request
  for (genvar p = 0; p < NUM_PORTS_C; p++) begin : g_cfg_check
    assert property (@(posedge clk156) disable iff (!rst_n)
      req && we && addr == {ntps_pkg::SLAVE_PORTS, ntps_pkg::reg_ofs_t'(p)}
      |-> ##2 (gen_config[p] == $past(wdata, 2)))
      else value_error("gen_config output", cfg_model[p], $sampled(gen_config[p]));
  end

  always @(posedge clk156) begin
    if (rst_n && rd_valid) begin
      if (exp_q.size() == 0) begin
        check_failed("Read data returned with no read outstanding");
      end else begin
        rd_exp  = exp_q.pop_front();
        rd_name = name_q.pop_front();
        assert (rd_data == rd_exp) else value_error(rd_name, rd_exp, rd_data);
      end
    end
  end

  // Limit grows with every issued request
  always @(posedge clk156) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > req_count * 10 + 200) begin
      $display("Timeout: the run did not finish within its cycle limit");
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    // Seed once for the whole run
    void'($urandom(32'h435c));
    rst_n = 1'b0;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    wdata = '0;
    ntp_time_a = '0;
    ntp_time_upd_a = 1'b0;
    ntp_sync_ok_a = 1'b0;
    ntp_time_b = '0;
    ntp_time_upd_b = 1'b0;
    ntp_sync_ok_b = 1'b0;
    user_link_up = 1'b0;
    for (int p = 0; p < NUM_PORTS_C; p++) begin
      xphy_status[p] = '0;
    end
    repeat (4) @(posedge clk156);
    rst_n <= 1'b1;

    @(posedge clk156);
    assert (rd_valid == 1'b0) else value_error("reset rd_valid", 0, rd_valid);
    assert (ntp_time == '0) else value_error("reset ntp_time", 0, ntp_time);
    assert (ntp_sync_ok == 1'b0) else value_error("reset ntp_sync_ok", 0, ntp_sync_ok);

    // Port config and status
    ntp_sync_ok_a <= 1'b1;
    user_link_up  <= 1'b1;
    for (int p = 0; p < NUM_PORTS_C; p++) begin
      xphy_status[p] <= ntps_pkg::xphy_status_t'($urandom);
    end
    for (int p = 0; p < NUM_PORTS_C; p++) begin
      cfg_model[p] = $urandom;
      if (p == 0) begin
        cfg_model[p][ntps_pkg::CLK_SEL_BIT] = 1'b0;
      end
      write_reg(reg_addr(ntps_pkg::SLAVE_PORTS, ntps_pkg::reg_ofs_t'(p)), cfg_model[p]);
    end
    for (int p = 0; p < NUM_PORTS_C; p++) begin
      read_check(reg_addr(ntps_pkg::SLAVE_PORTS, ntps_pkg::reg_ofs_t'(p)), cfg_model[p],
                 "port config readback");
      read_check(reg_addr(ntps_pkg::SLAVE_PORTS,
                          ntps_pkg::reg_ofs_t'(ntps_pkg::PORT_OFS_STATUS_BASE + p)),
                 {23'h0, 1'b1, 3'h0, xphy_status[p]}, "port status");
    end
    drain_reads();

    // Source A selected, B updates ignored
    tval = {$urandom, $urandom};
    pulse_time(1'b0, tval);
    pulse_time(1'b1, ~tval);
    read_check(reg_addr(ntps_pkg::SLAVE_NTP, ntps_pkg::NTP_OFS_TIME_HI), tval[63:32],
               "ntp time hi, source A");
    read_check(reg_addr(ntps_pkg::SLAVE_NTP, ntps_pkg::NTP_OFS_TIME_LO), tval[31:0],
               "ntp time lo, source A");
    // sync_b 0, sync_a 1, select 0
    read_check(reg_addr(ntps_pkg::SLAVE_NTP, ntps_pkg::NTP_OFS_STATUS), 32'h2,
               "ntp status, source A");

    // Switch to source B
    cfg_model[0][ntps_pkg::CLK_SEL_BIT] = 1'b1;
    write_reg(reg_addr(ntps_pkg::SLAVE_PORTS, 4'd0), cfg_model[0]);
    @(posedge clk156);
    ntp_sync_ok_a <= 1'b0;
    ntp_sync_ok_b <= 1'b1;
    tval = {$urandom, $urandom};
    pulse_time(1'b1, tval);
    pulse_time(1'b0, ~tval);
    read_check(reg_addr(ntps_pkg::SLAVE_NTP, ntps_pkg::NTP_OFS_TIME_HI), tval[63:32],
               "ntp time hi, source B");
    read_check(reg_addr(ntps_pkg::SLAVE_NTP, ntps_pkg::NTP_OFS_TIME_LO), tval[31:0],
               "ntp time lo, source B");
    read_check(reg_addr(ntps_pkg::SLAVE_NTP, ntps_pkg::NTP_OFS_STATUS), 32'h5,
               "ntp status, source B");
    read_check(reg_addr(ntps_pkg::SLAVE_PORTS, ntps_pkg::PORT_OFS_STATUS_BASE + 4'd3),
               {23'h0, 1'b1, 3'h0, xphy_status[3]}, "port status, sync from B");
    drain_reads();

    // Board info and link loss
    read_check(reg_addr(ntps_pkg::SLAVE_INFO, ntps_pkg::INFO_OFS_BUILD), BUILD_INFO_C,
               "build info");
    read_check(reg_addr(ntps_pkg::SLAVE_INFO, ntps_pkg::INFO_OFS_GIT), GIT_HASH_C, "git hash");
    read_check(reg_addr(ntps_pkg::SLAVE_INFO, ntps_pkg::INFO_OFS_LINK), 32'h1, "link up");
    user_link_up <= 1'b0;
    repeat (2) @(posedge clk156);
    read_check(reg_addr(ntps_pkg::SLAVE_INFO, ntps_pkg::INFO_OFS_LINK), 32'h2,
               "link lost after drop");
    user_link_up <= 1'b1;
    repeat (2) @(posedge clk156);
    write_reg(reg_addr(ntps_pkg::SLAVE_INFO, ntps_pkg::INFO_OFS_LINK), 32'h2);
    read_check(reg_addr(ntps_pkg::SLAVE_INFO, ntps_pkg::INFO_OFS_LINK), 32'h1,
               "link lost cleared");

    // Unmapped slave and offsets
    read_check(reg_addr(4'h5, 4'h0), ntps_pkg::BUS_ERR_DATA, "unmapped slave");
    read_check(reg_addr(ntps_pkg::SLAVE_NTP, 4'hF), ntps_pkg::BUS_ERR_DATA, "unmapped ntp ofs");
    read_check(reg_addr(ntps_pkg::SLAVE_PORTS, 4'hC), ntps_pkg::BUS_ERR_DATA,
               "unmapped port ofs");
    read_check(reg_addr(ntps_pkg::SLAVE_INFO, 4'h3), ntps_pkg::BUS_ERR_DATA,
               "unmapped info ofs");
    drain_reads();

    // Back-to-back reads across slaves
    issue(1'b0, reg_addr(ntps_pkg::SLAVE_INFO, ntps_pkg::INFO_OFS_BUILD), BUILD_INFO_C,
          "b2b build info");
    issue(1'b0, reg_addr(ntps_pkg::SLAVE_PORTS, 4'd2), cfg_model[2], "b2b port config");
    issue(1'b0, reg_addr(ntps_pkg::SLAVE_NTP, ntps_pkg::NTP_OFS_STATUS), 32'h5, "b2b ntp status");
    issue(1'b0, reg_addr(4'hE, 4'h1), ntps_pkg::BUS_ERR_DATA, "b2b unmapped slave");
    issue(1'b0, reg_addr(ntps_pkg::SLAVE_INFO, ntps_pkg::INFO_OFS_GIT), GIT_HASH_C,
          "b2b git hash");
    issue(1'b0, reg_addr(ntps_pkg::SLAVE_PORTS, ntps_pkg::PORT_OFS_STATUS_BASE + 4'd1),
          {23'h0, 1'b1, 3'h0, xphy_status[1]}, "b2b port status");
    bus_idle();
    drain_reads();

    repeat (4) @(posedge clk156);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== files.f ====
hw/ntps_pkg.sv
hw/reg_bus_if.sv
hw/host_bus_decoder.sv
hw/ntp_clock_select.sv
hw/port_config_regs.sv
hw/board_info_regs.sv
hw/ntps_ctrl_top.sv
bench/tb_ntps_ctrl_top.sv

// ==== Bender.yml ====
package:
  name: ntps_ctrl

sources:
  - hw/ntps_pkg.sv
  - hw/reg_bus_if.sv
  - hw/host_bus_decoder.sv
  - hw/ntp_clock_select.sv
  - hw/port_config_regs.sv
  - hw/board_info_regs.sv
  - hw/ntps_ctrl_top.sv
  - target: test
    files:
      - bench/tb_ntps_ctrl_top.sv
